// File: design/rf_pkg.sv
`default_nettype none

package rf_pkg;

    // -------------------------------------------------------------------------
    // architectural sizes
    // -------------------------------------------------------------------------
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int IDX_W     = $clog2(REG_COUNT);

    // -------------------------------------------------------------------------
    // register file types
    // -------------------------------------------------------------------------
    // x0..x31 index
    typedef logic [IDX_W-1:0] reg_idx_t;

    // one register value
    typedef logic [XLEN-1:0] reg_data_t;

    // whole file side by side, entry 0 stays zero
    typedef reg_data_t [REG_COUNT-1:0] reg_array_t;

    // one bit per register
    typedef logic [REG_COUNT-1:0] reg_mask_t;

endpackage

`default_nettype wire

// File: design/rf_write_arbiter.sv
`default_nettype none

module rf_write_arbiter #(
    parameter int NUM_WRITE_PORTS = 2
) (
    input  wire rf_pkg::reg_idx_t  [NUM_WRITE_PORTS-1:0] rd_idx_i,
    input  wire rf_pkg::reg_data_t [NUM_WRITE_PORTS-1:0] rd_value_i,
    output rf_pkg::reg_mask_t                            wr_en_o,
    output rf_pkg::reg_array_t                           wr_data_o
);

    import rf_pkg::*;

    // register targeted by each port
    reg_mask_t [NUM_WRITE_PORTS-1:0] port_hit;

    // -------------------------------------------------------------------------
    // destination decode
    // -------------------------------------------------------------------------
    // rd == x0 means the port is idle this cycle
    always_comb
    begin
        for (int p = 0; p < NUM_WRITE_PORTS; p++)
        begin
            port_hit[p] = '0;
            if (rd_idx_i[p] != '0)
            begin
                port_hit[p][rd_idx_i[p]] = 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // port priority
    // -------------------------------------------------------------------------
    // walk ports high to low so port 0 is applied last and wins
    always_comb
    begin
        wr_en_o   = '0;
        wr_data_o = '0;
        for (int r = 1; r < REG_COUNT; r++)
        begin
            for (int p = NUM_WRITE_PORTS - 1; p >= 0; p--)
            begin
                if (port_hit[p][r])
                begin
                    wr_en_o[r]   = 1'b1;
                    wr_data_o[r] = rd_value_i[p];
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    // an active port always reaches its register
    for (genvar p = 0; p < NUM_WRITE_PORTS; p++)
    begin : g_port_chk
        always_comb
        begin
            if (rd_idx_i[p] != '0)
            begin
                assert final (wr_en_o[rd_idx_i[p]] == 1'b1)
                    else $error("write port %0d to x%0d got no enable", p, rd_idx_i[p]);
            end
        end
    end

    // port 0 data wins any clash
    always_comb
    begin
        if (rd_idx_i[0] != '0)
        begin
            assert final (wr_data_o[rd_idx_i[0]] == rd_value_i[0])
                else $error("write port 0 lost priority on x%0d", rd_idx_i[0]);
        end
    end

endmodule

`default_nettype wire

// File: design/rf_storage.sv
`default_nettype none

module rf_storage (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire rf_pkg::reg_mask_t  wr_en_i,
    input  wire rf_pkg::reg_array_t wr_data_i,
    output rf_pkg::reg_array_t      regs_o
);

    import rf_pkg::*;

    // x1..x31 only, x0 has no flop
    reg_data_t [REG_COUNT-1:1] regs_q;

    // -------------------------------------------------------------------------
    // write back
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            regs_q <= '0;
        end
        else
        begin
            for (int r = 1; r < REG_COUNT; r++)
            begin
                if (wr_en_i[r])
                begin
                    regs_q[r] <= wr_data_i[r];
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // register view
    // -------------------------------------------------------------------------
    always_comb
    begin
        regs_o[0] = '0;
        for (int r = 1; r < REG_COUNT; r++)
        begin
            regs_o[r] = regs_q[r];
        end
    end

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    // a register without an enable holds over the edge
    for (genvar r = 1; r < REG_COUNT; r++)
    begin : g_hold_chk
        assert property (@(posedge clk_i) disable iff (rst_i)
            !wr_en_i[r] |=> $stable(regs_o[r]))
            else $error("x%0d changed with no write enable", r);
    end

endmodule

`default_nettype wire

// File: design/rf_read_mux.sv
`default_nettype none

module rf_read_mux #(
    parameter int NUM_READ_PORTS = 4
) (
    input  wire rf_pkg::reg_array_t                     regs_i,
    input  wire rf_pkg::reg_idx_t  [NUM_READ_PORTS-1:0] rs_idx_i,
    output rf_pkg::reg_data_t      [NUM_READ_PORTS-1:0] rs_value_o
);

    import rf_pkg::*;

    // -------------------------------------------------------------------------
    // source select
    // -------------------------------------------------------------------------
    // no bypass, a register written this cycle still shows its old value
    // x0 comes through as entry 0, which storage holds at zero
    always_comb
    begin
        for (int p = 0; p < NUM_READ_PORTS; p++)
        begin
            rs_value_o[p] = regs_i[rs_idx_i[p]];
        end
    end

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    // x0 must read zero on every port regardless of earlier writes
    for (genvar p = 0; p < NUM_READ_PORTS; p++)
    begin : g_x0_chk
        always_comb
        begin
            if (rs_idx_i[p] == reg_idx_t'(0))
            begin
                assert final (rs_value_o[p] == reg_data_t'(0))
                    else $error("read port %0d returned %h for x0", p, rs_value_o[p]);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rf_top.sv
`default_nettype none

module rf_top #(
    parameter int NUM_WRITE_PORTS = 2,
    parameter int NUM_READ_PORTS  = 4
) (
    input  wire logic                                          clk_i,
    input  wire logic                                          rst_i,

    // write back, rd == 0 means no write
    input  wire logic [NUM_WRITE_PORTS-1:0][rf_pkg::IDX_W-1:0] rd_idx_i,
    input  wire logic [NUM_WRITE_PORTS-1:0][rf_pkg::XLEN-1:0]  rd_value_i,

    // operand reads
    input  wire logic [NUM_READ_PORTS-1:0][rf_pkg::IDX_W-1:0]  rs_idx_i,
    output logic      [NUM_READ_PORTS-1:0][rf_pkg::XLEN-1:0]   rs_value_o
);

    import rf_pkg::*;

    reg_mask_t  wr_en;
    reg_array_t wr_data;
    reg_array_t regs;

    // -------------------------------------------------------------------------
    // write side
    // -------------------------------------------------------------------------
    rf_write_arbiter #(
        .NUM_WRITE_PORTS (NUM_WRITE_PORTS)
    ) u_write_arbiter (
        .rd_idx_i   (rd_idx_i),
        .rd_value_i (rd_value_i),
        .wr_en_o    (wr_en),
        .wr_data_o  (wr_data)
    );

    // -------------------------------------------------------------------------
    // storage
    // -------------------------------------------------------------------------
    rf_storage u_storage (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .regs_o    (regs)
    );

    // -------------------------------------------------------------------------
    // read side
    // -------------------------------------------------------------------------
    rf_read_mux #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) u_read_mux (
        .regs_i     (regs),
        .rs_idx_i   (rs_idx_i),
        .rs_value_o (rs_value_o)
    );

endmodule

`default_nettype wire

// File: verification/rf_tb.sv
`default_nettype none

module rf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rf_pkg::*;

    localparam int    NUM_WRITE_PORTS = 2;
    localparam int    NUM_READ_PORTS  = 4;
    localparam int    RESET_CYCLES    = 16;
    localparam int    MAX_LINES       = 70;
    localparam int    TIMEOUT_CYCLES  = RESET_CYCLES + 2 * MAX_LINES;
    localparam string STIM_FILE       = "verification/rf_stimulus.txt";

    logic                                  clk_i;
    logic                                  rst_i;
    logic [NUM_WRITE_PORTS-1:0][IDX_W-1:0] rd_idx_i;
    logic [NUM_WRITE_PORTS-1:0][XLEN-1:0]  rd_value_i;
    logic [NUM_READ_PORTS-1:0][IDX_W-1:0]  rs_idx_i;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]   rs_value_o;

    // current vector as read from the stimulus file
    int        vec_test;
    int        vec_wr_idx [NUM_WRITE_PORTS];
    reg_data_t vec_wr_val [NUM_WRITE_PORTS];
    int        vec_rs_idx [NUM_READ_PORTS];
    reg_data_t vec_exp    [NUM_READ_PORTS];

    int fd;
    int check_count;
    int fail_count;
    int bad_lines;
    int test_checks;
    int test_fails;
    int cycle_count;

    rf_top UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_idx_i   (rd_idx_i),
        .rd_value_i (rd_value_i),
        .rs_idx_i   (rs_idx_i),
        .rs_value_o (rs_value_o)
    );

    // -------------------------------------------------------------------------
    // clock and watchdog
    // -------------------------------------------------------------------------
    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // -------------------------------------------------------------------------
    // stimulus helpers
    // -------------------------------------------------------------------------
    // skips comment and blank lines
    // found stays low at end of file
    task automatic fetch_vector(output bit found);
        string line;
        int    code;
        found = 1'b0;
        while (!found && !$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0)
            begin
                code = $sscanf(line, "%d %d %h %d %h %d %d %d %d %h %h %h %h",
                               vec_test,
                               vec_wr_idx[0], vec_wr_val[0],
                               vec_wr_idx[1], vec_wr_val[1],
                               vec_rs_idx[0], vec_rs_idx[1],
                               vec_rs_idx[2], vec_rs_idx[3],
                               vec_exp[0], vec_exp[1], vec_exp[2], vec_exp[3]);
                if (code == 13)
                begin
                    found = 1'b1;
                end
                else if (code > 0)
                begin
                    $display("a stimulus line could not be read: %s", line);
                    bad_lines++;
                end
            end
        end
    endtask

    task automatic drive_vector();
        for (int p = 0; p < NUM_WRITE_PORTS; p++)
        begin
            rd_idx_i[p]   <= reg_idx_t'(vec_wr_idx[p]);
            rd_value_i[p] <= vec_wr_val[p];
        end
        for (int p = 0; p < NUM_READ_PORTS; p++)
        begin
            rs_idx_i[p] <= reg_idx_t'(vec_rs_idx[p]);
        end
    endtask

    task automatic check_reads();
        for (int p = 0; p < NUM_READ_PORTS; p++)
        begin
            check_count++;
            test_checks++;
            assert (rs_value_o[p] == vec_exp[p])
            else
            begin
                $display("FAILED at %0d ns: test %0d port %0d x%0d expected %h got %h",
                         $time, vec_test, p, vec_rs_idx[p], vec_exp[p], rs_value_o[p]);
                fail_count++;
                test_fails++;
            end
        end
    endtask

    task automatic report_test(input int num);
        $display("test %0d done: %0d checks, %0d failed", num, test_checks, test_fails);
    endtask

    // -------------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------------
    initial
    begin : main
        bit found;
        bit open_failed;
        int cur_test;

        rst_i       = 1'b1;
        rd_idx_i    = '0;
        rd_value_i  = '0;
        rs_idx_i    = '0;
        check_count = 0;
        fail_count  = 0;
        bad_lines   = 0;
        test_checks = 0;
        test_fails  = 0;
        cur_test    = -1;

        fd = $fopen(STIM_FILE, "r");
        open_failed = (fd == 0);

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        if (open_failed)
        begin
            $display("the stimulus file %s could not be opened", STIM_FILE);
        end
        else
        begin
            fetch_vector(found);
            while (found)
            begin
                if (vec_test != cur_test)
                begin
                    if (cur_test >= 0)
                    begin
                        report_test(cur_test);
                    end
                    cur_test    = vec_test;
                    test_checks = 0;
                    test_fails  = 0;
                end
                @(posedge clk_i);
                drive_vector();
                // reads settle well before the falling edge
                @(negedge clk_i);
                check_reads();
                fetch_vector(found);
            end
            if (cur_test >= 0)
            begin
                report_test(cur_test);
            end
            $fclose(fd);
        end

        $display("checks passed: %0d, failed: %0d, unreadable lines: %0d",
                 check_count - fail_count, fail_count, bad_lines);
        if (!open_failed && fail_count == 0 && bad_lines == 0 && check_count > 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/rf_stimulus.txt
# test wr0_idx wr0_val wr1_idx wr1_val rs0 rs1 rs2 rs3 exp0 exp1 exp2 exp3
# indices in decimal, values in hex, expected values are the reads seen in that same cycle
1  0 00000000  0 00000000   0  1  2  3  00000000 00000000 00000000 00000000
1  0 00000000  0 00000000   4  5  6  7  00000000 00000000 00000000 00000000
1  0 00000000  0 00000000   8 15 16 31  00000000 00000000 00000000 00000000
1  0 00000000  0 00000000   9 17 29 30  00000000 00000000 00000000 00000000
2  5 12345678  9 deadbeef   5  9  0  1  00000000 00000000 00000000 00000000
2  0 00000000  0 00000000   5  5  5  5  12345678 12345678 12345678 12345678
2  0 00000000  0 00000000   9  9  9  9  deadbeef deadbeef deadbeef deadbeef
2  0 00000000  0 00000000   5  9  5  9  12345678 deadbeef 12345678 deadbeef
3  0 ffffffff  0 a5a5a5a5   0  0  5  9  00000000 00000000 12345678 deadbeef
3  0 11111111  0 22222222   0  0  0  0  00000000 00000000 00000000 00000000
3  0 00000000  0 00000000   0  5  9  0  00000000 12345678 deadbeef 00000000
3  0 cafef00d  3 00000033   0  3  0  3  00000000 00000000 00000000 00000000
3  0 00000000  0 00000000   3  0  3  0  00000033 00000000 00000033 00000000
4  7 aaaa0000  7 bbbb1111   7  7  7  7  00000000 00000000 00000000 00000000
4  0 00000000  0 00000000   7  7  7  7  aaaa0000 aaaa0000 aaaa0000 aaaa0000
4  5 55550000  5 66661111   5  5  5  5  12345678 12345678 12345678 12345678
4  0 00000000  0 00000000   5  7  5  7  55550000 aaaa0000 55550000 aaaa0000
5  3 33333333  9 99999999   3  9  3  9  00000033 deadbeef 00000033 deadbeef
5  3 44444444  0 00000000   3  9  3  9  33333333 99999999 33333333 99999999
5  0 00000000  3 5a5a5a5a   3  3  3  3  44444444 44444444 44444444 44444444
5  0 00000000  0 00000000   3  3  9  9  5a5a5a5a 5a5a5a5a 99999999 99999999
6  1 01c0de01  2 02c0de02   0  0  1  2  00000000 00000000 00000000 00000000
6  3 03c0de03  4 04c0de04   1  2  3  4  01c0de01 02c0de02 5a5a5a5a 00000000
6  5 05c0de05  6 06c0de06   3  4  5  6  03c0de03 04c0de04 55550000 00000000
6  7 07c0de07  8 08c0de08   5  6  7  8  05c0de05 06c0de06 aaaa0000 00000000
6  9 09c0de09 10 0ac0de0a   7  8  9 10  07c0de07 08c0de08 99999999 00000000
6 11 0bc0de0b 12 0cc0de0c   9 10 11 12  09c0de09 0ac0de0a 00000000 00000000
6 13 0dc0de0d 14 0ec0de0e  11 12 13 14  0bc0de0b 0cc0de0c 00000000 00000000
6 15 0fc0de0f 16 10c0de10  13 14 15 16  0dc0de0d 0ec0de0e 00000000 00000000
6 17 11c0de11 18 12c0de12  15 16 17 18  0fc0de0f 10c0de10 00000000 00000000
6 19 13c0de13 20 14c0de14  17 18 19 20  11c0de11 12c0de12 00000000 00000000
6 21 15c0de15 22 16c0de16  19 20 21 22  13c0de13 14c0de14 00000000 00000000
6 23 17c0de17 24 18c0de18  21 22 23 24  15c0de15 16c0de16 00000000 00000000
6 25 19c0de19 26 1ac0de1a  23 24 25 26  17c0de17 18c0de18 00000000 00000000
6 27 1bc0de1b 28 1cc0de1c  25 26 27 28  19c0de19 1ac0de1a 00000000 00000000
6 29 1dc0de1d 30 1ec0de1e  27 28 29 30  1bc0de1b 1cc0de1c 00000000 00000000
6 31 1fc0de1f  0 00000000  29 30 31  0  1dc0de1d 1ec0de1e 00000000 00000000
6  0 00000000  0 00000000   0  8 16 24  00000000 08c0de08 10c0de10 18c0de18
6  0 00000000  0 00000000   1  9 17 25  01c0de01 09c0de09 11c0de11 19c0de19
6  0 00000000  0 00000000   2 10 18 26  02c0de02 0ac0de0a 12c0de12 1ac0de1a
6  0 00000000  0 00000000   3 11 19 27  03c0de03 0bc0de0b 13c0de13 1bc0de1b
6  0 00000000  0 00000000   4 12 20 28  04c0de04 0cc0de0c 14c0de14 1cc0de1c
6  0 00000000  0 00000000   5 13 21 29  05c0de05 0dc0de0d 15c0de15 1dc0de1d
6  0 00000000  0 00000000   6 14 22 30  06c0de06 0ec0de0e 16c0de16 1ec0de1e
6  0 00000000  0 00000000   7 15 23 31  07c0de07 0fc0de0f 17c0de17 1fc0de1f
6  0 00000000  0 00000000   8 16 24  0  08c0de08 10c0de10 18c0de18 00000000
6  0 00000000  0 00000000   9 17 25  1  09c0de09 11c0de11 19c0de19 01c0de01
6  0 00000000  0 00000000  10 18 26  2  0ac0de0a 12c0de12 1ac0de1a 02c0de02
6  0 00000000  0 00000000  11 19 27  3  0bc0de0b 13c0de13 1bc0de1b 03c0de03
6  0 00000000  0 00000000  12 20 28  4  0cc0de0c 14c0de14 1cc0de1c 04c0de04
6  0 00000000  0 00000000  13 21 29  5  0dc0de0d 15c0de15 1dc0de1d 05c0de05
6  0 00000000  0 00000000  14 22 30  6  0ec0de0e 16c0de16 1ec0de1e 06c0de06
6  0 00000000  0 00000000  15 23 31  7  0fc0de0f 17c0de17 1fc0de1f 07c0de07
6  0 00000000  0 00000000  16 24  0  8  10c0de10 18c0de18 00000000 08c0de08
6  0 00000000  0 00000000  17 25  1  9  11c0de11 19c0de19 01c0de01 09c0de09
6  0 00000000  0 00000000  18 26  2 10  12c0de12 1ac0de1a 02c0de02 0ac0de0a
6  0 00000000  0 00000000  19 27  3 11  13c0de13 1bc0de1b 03c0de03 0bc0de0b
6  0 00000000  0 00000000  20 28  4 12  14c0de14 1cc0de1c 04c0de04 0cc0de0c
6  0 00000000  0 00000000  21 29  5 13  15c0de15 1dc0de1d 05c0de05 0dc0de0d
6  0 00000000  0 00000000  22 30  6 14  16c0de16 1ec0de1e 06c0de06 0ec0de0e
6  0 00000000  0 00000000  23 31  7 15  17c0de17 1fc0de1f 07c0de07 0fc0de0f
6  0 00000000  0 00000000  24  0  8 16  18c0de18 00000000 08c0de08 10c0de10
6  0 00000000  0 00000000  25  1  9 17  19c0de19 01c0de01 09c0de09 11c0de11
6  0 00000000  0 00000000  26  2 10 18  1ac0de1a 02c0de02 0ac0de0a 12c0de12
6  0 00000000  0 00000000  27  3 11 19  1bc0de1b 03c0de03 0bc0de0b 13c0de13
6  0 00000000  0 00000000  28  4 12 20  1cc0de1c 04c0de04 0cc0de0c 14c0de14
6  0 00000000  0 00000000  29  5 13 21  1dc0de1d 05c0de05 0dc0de0d 15c0de15
6  0 00000000  0 00000000  30  6 14 22  1ec0de1e 06c0de06 0ec0de0e 16c0de16
6  0 00000000  0 00000000  31  7 15 23  1fc0de1f 07c0de07 0fc0de0f 17c0de17

// File: build.f
design/rf_pkg.sv
design/rf_write_arbiter.sv
design/rf_storage.sv
design/rf_read_mux.sv
design/rf_top.sv
verification/rf_tb.sv

// File: run.sh
#!/bin/sh
# build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rf_tb -f build.f -o rf_sim || exit 1

sim_out=$(./obj_dir/rf_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
